// File: src/muldiv_pkg.sv
`default_nettype none

package muldiv_pkg;

	// operand and result width
	localparam int xlen = 32;
	// each partial-product factor is one half of an operand
	localparam int half_len = xlen / 2;

	// opcode encoding, also used by the test data file
	typedef enum logic [2:0]
	{
		op_slt  = 3'd0,
		op_sltu = 3'd1,
		op_mul  = 3'd2,
		op_div  = 3'd3,
		op_divu = 3'd4,
		op_rem  = 3'd5,
		op_remu = 3'd6
	} alu_op_e;

	typedef struct packed
	{
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
	} mul_cmd_t;

	typedef struct packed
	{
		logic [xlen-1:0] num;
		logic [xlen-1:0] denom;
		// magnitudes and sign fix-up only when set
		logic is_signed;
	} div_cmd_t;

	typedef struct packed
	{
		logic [xlen-1:0] quot;
		logic [xlen-1:0] rem;
	} div_rsp_t;

	// 3 + 32 + 32 = 67 bits
	typedef struct packed
	{
		alu_op_e op;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
	} alu_cmd_t;

	typedef struct packed
	{
		logic lt_signed;
		logic lt_unsigned;
	} cmp_rsp_t;

	typedef enum logic [1:0]
	{
		st_mul_idle,
		st_mul_partial,
		st_mul_sum
	} mul_state_e;

	typedef enum logic [1:0]
	{
		st_div_idle,
		st_div_init,
		st_div_iter,
		st_div_fix
	} div_state_e;

endpackage

`default_nettype wire

// File: src/operand_compare.sv
`default_nettype none

module operand_compare import muldiv_pkg::*;
(
	input logic [xlen-1:0] a,
	input logic [xlen-1:0] b,
	output cmp_rsp_t cmp
);

	// a - b as a + ~b + 1, with the carry kept
	logic [xlen-1:0] diff;
	logic carry;
	// set when a and b differ in sign and the result sign flipped
	logic ovf;

	always_comb
	begin
		{carry, diff} = {1'b0, a} + {1'b0, ~b} + {{xlen{1'b0}}, 1'b1};
		ovf = (a[xlen-1] ^ b[xlen-1]) & (a[xlen-1] ^ diff[xlen-1]);
		// no carry out means a borrow, so a < b unsigned
		cmp.lt_unsigned = ~carry;
		// sign of the difference, corrected for overflow
		cmp.lt_signed = diff[xlen-1] ^ ovf;
	end

endmodule

`default_nettype wire

// File: src/mul_unit.sv
`default_nettype none

module mul_unit import muldiv_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input mul_cmd_t cmd,
	output logic done,
	output logic [xlen-1:0] prod
);

	mul_state_e state;

	// operands held for the whole operation
	mul_cmd_t opnd;

	// partial products, each factor is half_len bits
	logic [xlen-1:0] pp_ll;
	logic [xlen-1:0] pp_lh;
	logic [xlen-1:0] pp_hl;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= st_mul_idle;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				st_mul_idle:
				begin
					if (start)
					begin
						opnd <= cmd;
						state <= st_mul_partial;
					end
				end
				st_mul_partial:
				begin
					// three products in parallel
					// high x high only lands above bit xlen-1, so it is skipped
					pp_ll <= xlen'(opnd.a[half_len-1:0]) * xlen'(opnd.b[half_len-1:0]);
					pp_lh <= xlen'(opnd.a[half_len-1:0]) * xlen'(opnd.b[xlen-1:half_len]);
					pp_hl <= xlen'(opnd.a[xlen-1:half_len]) * xlen'(opnd.b[half_len-1:0]);
					state <= st_mul_sum;
				end
				st_mul_sum:
				begin
					// cross terms shifted up, truncated to the low word
					prod <= pp_ll + ((pp_lh + pp_hl) << half_len);
					done <= 1'b1;
					state <= st_mul_idle;
				end
				default:
				begin
					state <= st_mul_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/div_unit.sv
`default_nettype none

module div_unit import muldiv_pkg::*;
#(
	parameter int width = xlen,
	parameter int steps_per_cycle = 1
)
(
	input logic clk,
	input logic rst,
	input logic start,
	input div_cmd_t cmd,
	output logic done,
	output div_rsp_t rsp
);

	// partial remainder is double width plus a sign bit
	localparam int p_w = 2 * width + 1;
	localparam int cnt_w = $clog2(width + 1);

	div_state_e state;

	// operand magnitudes and the sign rules to apply at the end
	logic [width-1:0] num_mag;
	logic [width-1:0] den_mag;
	logic quot_neg;
	logic rem_neg;

	// iteration registers
	logic [p_w-1:0] p;
	logic [p_w-1:0] d;
	logic [width-1:0] q;
	logic [cnt_w-1:0] cnt;

	logic [p_w-1:0] p_next;
	logic [width-1:0] q_next;
	logic [cnt_w-1:0] cnt_next;

	// fix-up terms
	logic [width-1:0] q_conv;
	logic [width-1:0] quot_mag;
	logic [p_w-1:0] p_fix;
	logic [width-1:0] rem_mag;

	// steps_per_cycle non-restoring steps, stopping once all bits are done
	always_comb
	begin
		p_next = p;
		q_next = q;
		cnt_next = cnt;
		for (int i = 0; i < steps_per_cycle; i++)
		begin
			if (cnt_next != '0)
			begin
				// non-negative remainder: subtract, digit +1
				if (!p_next[p_w-1])
				begin
					p_next = (p_next << 1) - d;
					q_next = {q_next[width-2:0], 1'b1};
				end
				// negative: add back, digit -1
				else
				begin
					p_next = (p_next << 1) + d;
					q_next = {q_next[width-2:0], 1'b0};
				end
				cnt_next = cnt_next - cnt_w'(1);
			end
		end
	end

	always_comb
	begin
		// +1/-1 digits to binary
		q_conv = q - ~q;
		// one step too far when the last remainder went negative
		quot_mag = p[p_w-1] ? q_conv - width'(1) : q_conv;
		p_fix = p[p_w-1] ? p + d : p;
		rem_mag = p_fix[width +: width];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= st_div_idle;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				st_div_idle:
				begin
					if (start)
					begin
						num_mag <= (cmd.is_signed && cmd.num[width-1]) ? -cmd.num : cmd.num;
						den_mag <= (cmd.is_signed && cmd.denom[width-1]) ? -cmd.denom : cmd.denom;
						quot_neg <= cmd.is_signed && (cmd.num[width-1] ^ cmd.denom[width-1]);
						rem_neg <= cmd.is_signed && cmd.num[width-1];
						state <= st_div_init;
					end
				end
				st_div_init:
				begin
					p <= {{(width + 1){1'b0}}, num_mag};
					// divisor aligned to the upper half
					d <= {1'b0, den_mag, {width{1'b0}}};
					q <= '0;
					cnt <= cnt_w'(width);
					state <= st_div_iter;
				end
				st_div_iter:
				begin
					p <= p_next;
					q <= q_next;
					cnt <= cnt_next;
					if (cnt_next == '0)
						state <= st_div_fix;
				end
				st_div_fix:
				begin
					// quotient truncates toward zero, remainder follows the numerator
					rsp.quot <= quot_neg ? -quot_mag : quot_mag;
					rsp.rem <= rem_neg ? -rem_mag : rem_mag;
					done <= 1'b1;
					state <= st_div_idle;
				end
				default:
				begin
					state <= st_div_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/muldiv_unit.sv
`default_nettype none

module muldiv_unit import muldiv_pkg::*;
#(
	parameter int div_steps_per_cycle = 1
)
(
	input logic clk,
	input logic rst,
	input logic cmd_valid,
	input alu_cmd_t cmd,
	output logic cmd_ready,
	output logic rsp_valid,
	output logic [xlen-1:0] rsp_data
);

	// one command in flight
	logic busy;
	logic accept;
	// compare result waiting one cycle
	logic cmp_pend;
	logic cmp_bit_q;
	// opcode kept to pick quotient or remainder
	alu_op_e op_q;

	cmp_rsp_t cmp;
	logic mul_start;
	logic mul_done;
	logic [xlen-1:0] mul_prod;
	logic div_start;
	logic div_done;
	div_rsp_t div_rsp;

	assign cmd_ready = !busy;
	assign accept = cmd_valid && cmd_ready;
	// units start on the accepting edge itself
	assign mul_start = accept && (cmd.op == op_mul);
	assign div_start = accept && (cmd.op inside {op_div, op_divu, op_rem, op_remu});

	operand_compare u_cmp (.a(cmd.a), .b(cmd.b), .cmp(cmp));

	mul_unit u_mul
	(
		.clk(clk), .rst(rst), .start(mul_start),
		.cmd('{a: cmd.a, b: cmd.b}),
		.done(mul_done), .prod(mul_prod)
	);

	div_unit #(.width(xlen), .steps_per_cycle(div_steps_per_cycle)) u_div
	(
		.clk(clk), .rst(rst), .start(div_start),
		.cmd('{num: cmd.a, denom: cmd.b, is_signed: (cmd.op == op_div) || (cmd.op == op_rem)}),
		.done(div_done), .rsp(div_rsp)
	);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			cmp_pend <= 1'b0;
			rsp_valid <= 1'b0;
		end
		else
		begin
			rsp_valid <= 1'b0;
			if (accept)
			begin
				busy <= 1'b1;
				op_q <= cmd.op;
				case (cmd.op)
					op_slt:
					begin
						cmp_pend <= 1'b1;
						cmp_bit_q <= cmp.lt_signed;
					end
					op_sltu:
					begin
						cmp_pend <= 1'b1;
						cmp_bit_q <= cmp.lt_unsigned;
					end
					op_mul, op_div, op_divu, op_rem, op_remu:
						cmp_pend <= 1'b0;
					// Unused encoding answers zero so the unit never hangs.
					default:
					begin
						cmp_pend <= 1'b1;
						cmp_bit_q <= 1'b0;
					end
				endcase
			end
			else if (cmp_pend)
			begin
				cmp_pend <= 1'b0;
				busy <= 1'b0;
				rsp_valid <= 1'b1;
				rsp_data <= {{(xlen - 1){1'b0}}, cmp_bit_q};
			end
			else if (mul_done)
			begin
				busy <= 1'b0;
				rsp_valid <= 1'b1;
				rsp_data <= mul_prod;
			end
			else if (div_done)
			begin
				busy <= 1'b0;
				rsp_valid <= 1'b1;
				rsp_data <= (op_q inside {op_rem, op_remu}) ? div_rsp.rem : div_rsp.quot;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/muldiv_tb.sv
`default_nettype none

module muldiv_tb import muldiv_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int timeout_cycles = 200;
	localparam int div_steps = 1;
	localparam string data_file = "tb/muldiv_testdata.txt";

	logic clk;
	logic rst;
	logic cmd_valid;
	alu_cmd_t cmd;
	logic cmd_ready;
	logic rsp_valid;
	logic [xlen-1:0] rsp_data;

	int pass_count;
	int fail_count;
	// handshake bookkeeping, sampled on the falling edge
	int accept_count;
	int rsp_count;

	muldiv_unit #(.div_steps_per_cycle(div_steps)) dut_i
	(
		.clk(clk),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_ready(cmd_ready),
		.rsp_valid(rsp_valid),
		.rsp_data(rsp_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// every accepted command and every response cycle
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (cmd_valid && cmd_ready)
				accept_count++;
			if (rsp_valid)
				rsp_count++;
		end
	end

	// one command, one response, value and latency checked
	task automatic run_test(input string name, input alu_op_e op, input logic [xlen-1:0] a,
		input logic [xlen-1:0] b, input logic [xlen-1:0] exp);
		int waited;
		int lat;
		int exp_lat;
		logic failed;
		failed = 1'b0;
		waited = 0;
		while (!cmd_ready && waited < timeout_cycles)
		begin
			@(negedge clk);
			waited++;
		end
		if (!cmd_ready)
		begin
			$display("%s: cmd_ready never came back high", name);
			fail_count++;
			return;
		end
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd.op <= op;
		cmd.a <= a;
		cmd.b <= b;
		// accepting edge
		@(posedge clk);
		cmd_valid <= 1'b0;
		lat = 0;
		@(negedge clk);
		while (!rsp_valid && lat < timeout_cycles)
		begin
			// busy until the response edge
			if (cmd_ready && !failed)
			begin
				$display("%s: cmd_ready went high before the response", name);
				failed = 1'b1;
			end
			@(negedge clk);
			lat++;
		end
		if (!rsp_valid)
		begin
			$display("%s: no response within %0d cycles", name, timeout_cycles);
			fail_count++;
			return;
		end
		if (op == op_slt || op == op_sltu)
			exp_lat = 1;
		else if (op == op_mul)
			exp_lat = 3;
		else
			exp_lat = -1;
		// divider latency not fixed here, only bounded by the timeout
		if (exp_lat >= 0 && lat != exp_lat)
		begin
			$display("** Error: %s latency expected %0d actual %0d", name, exp_lat, lat);
			failed = 1'b1;
		end
		if (rsp_data !== exp)
		begin
			$display("** Error: %s expected %h actual %h", name, exp, rsp_data);
			failed = 1'b1;
		end
		@(negedge clk);
		if (rsp_valid)
		begin
			$display("%s: rsp_valid stayed high longer than one cycle", name);
			failed = 1'b1;
		end
		if (failed)
			fail_count++;
		else
			pass_count++;
		$display("%s %s", name, failed ? "failed" : "passed");
	endtask

	initial
	begin
		int fd;
		int code;
		int n;
		int line_no;
		string line;
		string name;
		logic [2:0] op_raw;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [xlen-1:0] exp;
		pass_count = 0;
		fail_count = 0;
		accept_count = 0;
		rsp_count = 0;
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		// idle state straight after reset
		if (!cmd_ready || rsp_valid)
		begin
			$display("reset: cmd_ready low or rsp_valid high after reset");
			fail_count++;
		end
		else
			$display("reset passed");
		fd = $fopen(data_file, "r");
		if (fd == 0)
		begin
			$display("could not open %s", data_file);
			fail_count++;
		end
		else
		begin
			line_no = 0;
			while (!$feof(fd))
			begin
				line = "";
				code = $fgets(line, fd);
				line_no++;
				// skip blank lines and # comments
				if (code > 0 && line.len() > 1 && line.getc(0) != "#")
				begin
					name = $sformatf("test_%02d", line_no);
					n = $sscanf(line, "%h %h %h %h", op_raw, a, b, exp);
					if (n != 4)
					begin
						$display("%s: line does not hold four hex fields", name);
						fail_count++;
					end
					else
						run_test(name, alu_op_e'(op_raw), a, b, exp);
				end
			end
			$fclose(fd);
		end
		// time for any stray response to show up
		repeat (4) @(negedge clk);
		if (rsp_count != accept_count)
		begin
			$display("%0d commands accepted but %0d responses seen", accept_count, rsp_count);
			fail_count++;
		end
		if (pass_count == 0)
		begin
			$display("no test was run");
			fail_count++;
		end
		$display("passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/muldiv_testdata.txt
# columns: opcode a b expected, all hex
# opcode: 0 slt, 1 sltu, 2 mul, 3 div, 4 divu, 5 rem, 6 remu
0 00000001 00000002 00000001
1 00000001 00000002 00000001
0 80000000 00000001 00000001
1 80000000 00000001 00000000
0 00000001 80000000 00000000
1 00000001 80000000 00000001
0 ffffffff 7fffffff 00000001
1 ffffffff 7fffffff 00000000
0 00000005 00000005 00000000
0 00000003 80000003 00000000
1 00000003 80000003 00000001
2 00000003 00000007 00000015
2 ffffffff ffffffff 00000001
2 00010000 00010000 00000000
2 12345678 9abcdef0 242d2080
2 00030002 00050004 00160008
4 00000064 00000007 0000000e
6 00000064 00000007 00000002
4 00000003 0000000a 00000000
6 00000003 0000000a 00000003
4 ffffffff 00000010 0fffffff
6 ffffffff 00000010 0000000f
3 00000007 00000002 00000003
5 00000007 00000002 00000001
3 fffffff9 00000002 fffffffd
5 fffffff9 00000002 ffffffff
3 00000007 fffffffe fffffffd
5 00000007 fffffffe 00000001
3 fffffff9 fffffffe 00000003
5 fffffff9 fffffffe ffffffff
3 fffffffa 00000003 fffffffe

// File: project.f
src/muldiv_pkg.sv
src/operand_compare.sv
src/mul_unit.sv
src/div_unit.sv
src/muldiv_unit.sv
tb/muldiv_tb.sv

// File: Makefile
TOOL := verilator
FLAGS := --binary -j 0
TOP := muldiv_tb
FILELIST := project.f
BUILD_DIR := obj_dir
LOG := sim.log

.PHONY: sim clean

# pass or fail is decided by the log, not by the simulator exit status
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
